/* Bender.yml */
package:
  name: lsu

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - pipeline_types.sv
      - dcache_types.sv
      - ex_agu.sv
      - dcache.sv
      - mem.sv
      - lsu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - lsu_tb.sv

/* build.f */
+incdir+.
pipeline_types.sv
dcache_types.sv
ex_agu.sv
dcache.sv
mem.sv
lsu_top.sv
lsu_tb.sv

/* dcache.sv */
`timescale 1ns/1ps
`include "lsu_macros.svh"

module dcache (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   req_i,
    input  logic [`LSU_DATA_W-1:0] addr_i,
    input  logic                   we_i,
    input  logic [3:0]             wstrb_i,
    input  logic [`LSU_DATA_W-1:0] wdata_i,
    output logic                   ack_o,
    output logic [`LSU_DATA_W-1:0] rdata_o
);
    import dcache_types::*;

    localparam int CNT_W = $clog2(`LSU_REFILL_CYCLES + 1);

    cache_state_e state_q;
    logic [CNT_W-1:0] cnt_q;

    logic [`LSU_CACHE_LINES-1:0] valid_q;
    logic [TAG_W-1:0]            tag_q  [`LSU_CACHE_LINES];
    logic [`LSU_DATA_W-1:0]      line_q [`LSU_CACHE_LINES];
    logic [`LSU_DATA_W-1:0]      ram_q  [`LSU_RAM_WORDS];

    logic [INDEX_W-1:0]     index;
    logic [TAG_W-1:0]       tag;
    logic [WORD_ADDR_W-1:0] word_addr;
    logic                   hit;
    logic                   store_go;
    logic                   refill_done;

    function automatic logic [`LSU_DATA_W-1:0] merge_bytes(
        input logic [`LSU_DATA_W-1:0] old_word,
        input logic [`LSU_DATA_W-1:0] new_word,
        input logic [3:0]             strb
    );
        logic [`LSU_DATA_W-1:0] res;
        res = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[i*8 +: 8] = new_word[i*8 +: 8];
            end
        end
        return res;
    endfunction

    // addr_i is held by the master for the whole request
    assign index = addr_i[OFFSET_W +: INDEX_W];
    assign tag = addr_i[OFFSET_W + INDEX_W +: TAG_W];
    assign word_addr = addr_i[OFFSET_W +: WORD_ADDR_W];
    assign hit = valid_q[index] && (tag_q[index] == tag);
    assign store_go = (state_q == C_LOOKUP) && we_i;
    assign refill_done = (state_q == C_REFILL) && (cnt_q == '0);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= C_IDLE;
            ack_o <= 1'b0;
            cnt_q <= '0;
            valid_q <= '0;
        end else begin
            case (state_q)
                C_IDLE: begin
                    if (req_i) begin
                        state_q <= C_LOOKUP;
                    end
                end
                C_LOOKUP: begin
                    // stores never allocate, they ack on hit timing
                    if (we_i || hit) begin
                        ack_o <= 1'b1;
                        state_q <= C_ACK;
                    end else begin
                        cnt_q <= CNT_W'(`LSU_REFILL_CYCLES - 1);
                        state_q <= C_REFILL;
                    end
                end
                C_REFILL: begin
                    if (cnt_q == '0) begin
                        valid_q[index] <= 1'b1;
                        ack_o <= 1'b1;
                        state_q <= C_ACK;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                C_ACK: begin
                    if (!req_i) begin
                        ack_o <= 1'b0;
                        state_q <= C_IDLE;
                    end
                end
                default: state_q <= C_IDLE;
            endcase
        end
    end

    // write-through backing store
    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < `LSU_RAM_WORDS; i++) begin
                ram_q[i] <= '0;
            end
        end else if (store_go) begin
            ram_q[word_addr] <= merge_bytes(ram_q[word_addr], wdata_i, wstrb_i);
        end
    end

    always_ff @(posedge clk) begin
        if (store_go && hit) begin
            line_q[index] <= merge_bytes(line_q[index], wdata_i, wstrb_i);
        end else if (refill_done) begin
            line_q[index] <= ram_q[word_addr];
            tag_q[index] <= tag;
        end
        if ((state_q == C_LOOKUP) && !we_i && hit) begin
            rdata_o <= line_q[index];
        end else if (refill_done) begin
            rdata_o <= ram_q[word_addr];
        end
    end

    a_ack_needs_req: assert property (@(posedge clk) disable iff (rst_i)
        $rose(ack_o) |-> req_i);

endmodule

/* dcache_types.sv */
`include "lsu_macros.svh"

package dcache_types;

    typedef enum logic [1:0] {
        C_IDLE,
        C_LOOKUP,
        C_REFILL,
        C_ACK
    } cache_state_e;

    // byte offset inside a word
    localparam int OFFSET_W = 2;
    localparam int INDEX_W = $clog2(`LSU_CACHE_LINES);
    localparam int WORD_ADDR_W = $clog2(`LSU_RAM_WORDS);
    // tag covers only the RAM word address, upper bits alias
    localparam int TAG_W = WORD_ADDR_W - INDEX_W;

endpackage

/* ex_agu.sv */
`timescale 1ns/1ps
`include "lsu_macros.svh"

module ex_agu (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   op_valid_i,
    input  pipeline_types::aluop_e op_i,
    input  logic [`LSU_DATA_W-1:0] base_i,
    input  logic [`LSU_DATA_W-1:0] offset_i,
    input  logic [4:0]             rd_i,
    input  logic [`LSU_DATA_W-1:0] st_data_i,
    input  logic                   pause_i,
    output logic                   op_ready_o,
    output logic                   ex_valid_o,
    output pipeline_types::aluop_e ex_op_o,
    output logic [`LSU_DATA_W-1:0] ex_addr_o,
    output logic [4:0]             ex_rd_o,
    output logic [`LSU_DATA_W-1:0] ex_st_data_o
);
    import pipeline_types::*;

    logic [`LSU_DATA_W-1:0] eff_addr;

    assign eff_addr = base_i + offset_i;
    assign op_ready_o = !pause_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex_valid_o <= 1'b0;
        end else if (!pause_i) begin
            ex_valid_o <= op_valid_i;
        end
    end

    // stage register, held while mem is busy
    always_ff @(posedge clk) begin
        if (!pause_i) begin
            ex_op_o <= op_valid_i ? op_i : ALU_NOP;
            ex_addr_o <= eff_addr;
            ex_rd_o <= rd_i;
            ex_st_data_o <= st_data_i;
        end
    end

    // mem only stalls after it has taken the operation held here
    a_pause_after_transfer: assert property (@(posedge clk) disable iff (rst_i)
        $rose(pause_i) |-> $past(ex_valid_o && !pause_i));

endmodule

/* lsu_macros.svh */
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// data and address width
`define LSU_DATA_W 32

// backing store depth in words
`define LSU_RAM_WORDS 64

// direct mapped, one word per line
`define LSU_CACHE_LINES 8

// extra cycles a miss costs over a hit
`define LSU_REFILL_CYCLES 3

`endif

/* lsu_tb.sv */
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_tb;
    import pipeline_types::*;

    localparam int READY_TIMEOUT = 200;
    localparam int RESULT_TIMEOUT = 200;

    typedef struct packed {
        aluop_e                 op;
        logic [`LSU_DATA_W-1:0] base;
        logic [`LSU_DATA_W-1:0] offset;
        logic [4:0]             rd;
        logic [`LSU_DATA_W-1:0] st_data;
        logic                   we;
        logic [`LSU_DATA_W-1:0] data;
        excp_cause_e            cause;
    } vector_t;

    logic                   clk;
    logic                   rst_i;
    logic                   op_valid_i;
    aluop_e                 op_i;
    logic [`LSU_DATA_W-1:0] base_i;
    logic [`LSU_DATA_W-1:0] offset_i;
    logic [4:0]             rd_i;
    logic [`LSU_DATA_W-1:0] st_data_i;
    logic                   op_ready_o;
    logic                   wb_valid_o;
    logic                   wb_we_o;
    logic [4:0]             wb_rd_o;
    logic [`LSU_DATA_W-1:0] wb_data_o;
    logic                   excp_o;
    excp_cause_e            excp_cause_o;

    vector_t vectors[$];
    vector_t expected[$];
    int errors;
    int checked;

    lsu_top i_dut (
        .clk          (clk),
        .rst_i        (rst_i),
        .op_valid_i   (op_valid_i),
        .op_i         (op_i),
        .base_i       (base_i),
        .offset_i     (offset_i),
        .rd_i         (rd_i),
        .st_data_i    (st_data_i),
        .op_ready_o   (op_ready_o),
        .wb_valid_o   (wb_valid_o),
        .wb_we_o      (wb_we_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o),
        .excp_o       (excp_o),
        .excp_cause_o (excp_cause_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic end_run();
        $display("%0d vectors, %0d results checked, %0d errors", vectors.size(), checked, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    function automatic bit decode_op(input string name, output aluop_e op);
        decode_op = 1'b1;
        op = ALU_NOP;
        case (name)
            "nop":   op = ALU_NOP;
            "ld.b":  op = ALU_LDB;
            "ld.bu": op = ALU_LDBU;
            "ld.h":  op = ALU_LDH;
            "ld.hu": op = ALU_LDHU;
            "ld.w":  op = ALU_LDW;
            "ll.w":  op = ALU_LLW;
            "st.b":  op = ALU_STB;
            "st.h":  op = ALU_STH;
            "st.w":  op = ALU_STW;
            "sc.w":  op = ALU_SCW;
            default: decode_op = 1'b0;
        endcase
    endfunction

    task automatic load_vectors();
        int fd;
        int n;
        string line;
        string name;
        vector_t v;
        logic [31:0] f_base;
        logic [31:0] f_offset;
        logic [31:0] f_rd;
        logic [31:0] f_st;
        logic [31:0] f_we;
        logic [31:0] f_data;
        logic [31:0] f_cause;
        fd = $fopen("lsu_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open lsu_tests.txt");
            errors++;
            end_run();
        end
        while ($fgets(line, fd) != 0) begin
            // blank lines and comments
            if (line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %h %h %h %h %h %h %h", name, f_base, f_offset, f_rd,
                        f_st, f_we, f_data, f_cause);
            if (n != 8) begin
                $display("malformed line in lsu_tests.txt: %s", line);
                errors++;
                continue;
            end
            if (!decode_op(name, v.op)) begin
                $display("unknown opcode %s in lsu_tests.txt", name);
                errors++;
                continue;
            end
            v.base = f_base;
            v.offset = f_offset;
            v.rd = f_rd[4:0];
            v.st_data = f_st;
            v.we = f_we[0];
            v.data = f_data;
            v.cause = excp_cause_e'(f_cause[1:0]);
            vectors.push_back(v);
        end
        $fclose(fd);
    endtask

    // op_ready_o only moves at a rising edge, so the falling edge sees its final value
    task automatic wait_ready();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!op_ready_o && cycles < READY_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!op_ready_o) begin
            $display("timeout: op_ready_o stayed low for %0d cycles", READY_TIMEOUT);
            errors++;
            end_run();
        end
    endtask

    task automatic drive_vectors();
        foreach (vectors[i]) begin
            wait_ready();
            op_valid_i = 1'b1;
            op_i = vectors[i].op;
            base_i = vectors[i].base;
            offset_i = vectors[i].offset;
            rd_i = vectors[i].rd;
            st_data_i = vectors[i].st_data;
            expected.push_back(vectors[i]);
        end
        @(negedge clk);
        op_valid_i = 1'b0;
    endtask

    task automatic wait_writeback();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!wb_valid_o && cycles < RESULT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!wb_valid_o) begin
            $display("timeout: no writeback within %0d cycles", RESULT_TIMEOUT);
            errors++;
            end_run();
        end
    endtask

    task automatic check_result(input vector_t exp);
        checked++;
        assert (wb_rd_o === exp.rd) else begin
            $display("error: wb_rd_o = %h, expected %h (result %0d)", wb_rd_o, exp.rd, checked);
            errors++;
        end
        assert (wb_we_o === exp.we) else begin
            $display("error: wb_we_o = %h, expected %h (result %0d)", wb_we_o, exp.we, checked);
            errors++;
        end
        // data only means something when rd is written
        if (exp.we) begin
            assert (wb_data_o === exp.data) else begin
                $display("error: wb_data_o = %h, expected %h (result %0d)",
                         wb_data_o, exp.data, checked);
                errors++;
            end
        end
        assert (excp_o === (exp.cause != EXC_NONE)) else begin
            $display("error: excp_o = %h, expected %h (result %0d)",
                     excp_o, exp.cause != EXC_NONE, checked);
            errors++;
        end
        assert (excp_cause_o === exp.cause) else begin
            $display("error: excp_cause_o = %h, expected %h (result %0d)",
                     excp_cause_o, exp.cause, checked);
            errors++;
        end
    endtask

    task automatic collect_results();
        vector_t exp;
        foreach (vectors[i]) begin
            wait_writeback();
            if (expected.size() == 0) begin
                $display("writeback arrived with no operation outstanding");
                errors++;
            end else begin
                exp = expected.pop_front();
                check_result(exp);
            end
        end
        // pipeline should be quiet now
        repeat (20) begin
            @(negedge clk);
            if (wb_valid_o) begin
                $display("extra writeback after the last operation");
                errors++;
            end
        end
    endtask

    initial begin
        errors = 0;
        checked = 0;
        rst_i = 1'b1;
        op_valid_i = 1'b0;
        op_i = ALU_NOP;
        base_i = '0;
        offset_i = '0;
        rd_i = '0;
        st_data_i = '0;
        load_vectors();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        fork
            drive_vectors();
            collect_results();
        join
        end_run();
    end

endmodule

/* lsu_tests.txt */
# op base offset rd st_data exp_we exp_data exp_cause
# numbers in hex, cause 0 none, 1 misaligned load, 2 misaligned store
ld.w  40 0 01 00000000 1 00000000 0
st.w  10 0 02 a1b2c3d4 0 00000000 0
ld.w  0c 4 03 00000000 1 a1b2c3d4 0
st.w  20 0 04 80f17f9e 0 00000000 0
ld.b  20 0 05 00000000 1 ffffff9e 0
ld.b  20 1 06 00000000 1 0000007f 0
ld.b  20 2 07 00000000 1 fffffff1 0
ld.b  20 3 08 00000000 1 ffffff80 0
ld.bu 20 0 09 00000000 1 0000009e 0
ld.bu 20 1 0a 00000000 1 0000007f 0
ld.bu 20 2 0b 00000000 1 000000f1 0
ld.bu 20 3 0c 00000000 1 00000080 0
ld.h  20 0 0d 00000000 1 00007f9e 0
ld.h  20 2 0e 00000000 1 ffff80f1 0
ld.hu 20 0 0f 00000000 1 00007f9e 0
ld.hu 20 2 10 00000000 1 000080f1 0
st.w  30 0 11 11223344 0 00000000 0
st.b  30 1 12 123456aa 0 00000000 0
st.b  30 3 13 fedcbabb 0 00000000 0
ld.w  30 0 14 00000000 1 bb22aa44 0
st.b  30 0 15 000000cc 0 00000000 0
st.b  30 2 16 777777dd 0 00000000 0
ld.w  30 0 17 00000000 1 bbddaacc 0
st.h  30 2 18 1234cafe 0 00000000 0
ld.w  30 0 19 00000000 1 cafeaacc 0
st.h  30 0 1a 5678beef 0 00000000 0
ld.w  30 0 1b 00000000 1 cafebeef 0
ld.h  20 1 1c 00000000 0 00000000 1
st.w  20 2 1d deadbeef 0 00000000 2
ld.w  20 0 1e 00000000 1 80f17f9e 0
ll.w  50 0 01 00000000 1 00000000 0
sc.w  50 0 02 600dc0de 1 00000001 0
ld.w  50 0 03 00000000 1 600dc0de 0
ll.w  50 0 04 00000000 1 600dc0de 0
st.w  50 0 05 11111111 0 00000000 0
sc.w  50 0 06 22222222 1 00000000 0
ld.w  50 0 07 00000000 1 11111111 0
st.w  a0 0 08 13579bdf 0 00000000 0
ld.w  90 10 09 00000000 1 13579bdf 0
ld.w  a0 0 0a 00000000 1 13579bdf 0
nop   00 0 0b 00000000 0 00000000 0
ld.bu a0 3 0c 00000000 1 00000013 0

/* lsu_top.sv */
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_top (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic                        op_valid_i,
    input  pipeline_types::aluop_e      op_i,
    input  logic [`LSU_DATA_W-1:0]      base_i,
    input  logic [`LSU_DATA_W-1:0]      offset_i,
    input  logic [4:0]                  rd_i,
    input  logic [`LSU_DATA_W-1:0]      st_data_i,
    output logic                        op_ready_o,
    output logic                        wb_valid_o,
    output logic                        wb_we_o,
    output logic [4:0]                  wb_rd_o,
    output logic [`LSU_DATA_W-1:0]      wb_data_o,
    output logic                        excp_o,
    output pipeline_types::excp_cause_e excp_cause_o
);
    import pipeline_types::*;

    // ex_agu to mem
    logic                   ex_valid;
    aluop_e                 ex_op;
    logic [`LSU_DATA_W-1:0] ex_addr;
    logic [4:0]             ex_rd;
    logic [`LSU_DATA_W-1:0] ex_st_data;
    logic                   pause_mem;

    // mem to dcache
    logic                   dc_req;
    logic [`LSU_DATA_W-1:0] dc_addr;
    logic                   dc_we;
    logic [3:0]             dc_wstrb;
    logic [`LSU_DATA_W-1:0] dc_wdata;
    logic                   dc_ack;
    logic [`LSU_DATA_W-1:0] dc_rdata;

    ex_agu i_ex_agu (
        .clk          (clk),
        .rst_i        (rst_i),
        .op_valid_i   (op_valid_i),
        .op_i         (op_i),
        .base_i       (base_i),
        .offset_i     (offset_i),
        .rd_i         (rd_i),
        .st_data_i    (st_data_i),
        .pause_i      (pause_mem),
        .op_ready_o   (op_ready_o),
        .ex_valid_o   (ex_valid),
        .ex_op_o      (ex_op),
        .ex_addr_o    (ex_addr),
        .ex_rd_o      (ex_rd),
        .ex_st_data_o (ex_st_data)
    );

    mem i_mem (
        .clk          (clk),
        .rst_i        (rst_i),
        .ex_valid_i   (ex_valid),
        .ex_op_i      (ex_op),
        .ex_addr_i    (ex_addr),
        .ex_rd_i      (ex_rd),
        .ex_st_data_i (ex_st_data),
        .dc_ack_i     (dc_ack),
        .dc_rdata_i   (dc_rdata),
        .pause_o      (pause_mem),
        .dc_req_o     (dc_req),
        .dc_addr_o    (dc_addr),
        .dc_we_o      (dc_we),
        .dc_wstrb_o   (dc_wstrb),
        .dc_wdata_o   (dc_wdata),
        .wb_valid_o   (wb_valid_o),
        .wb_we_o      (wb_we_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o),
        .excp_o       (excp_o),
        .excp_cause_o (excp_cause_o)
    );

    dcache i_dcache (
        .clk     (clk),
        .rst_i   (rst_i),
        .req_i   (dc_req),
        .addr_i  (dc_addr),
        .we_i    (dc_we),
        .wstrb_i (dc_wstrb),
        .wdata_i (dc_wdata),
        .ack_o   (dc_ack),
        .rdata_o (dc_rdata)
    );

endmodule

/* mem.sv */
`timescale 1ns/1ps
`include "lsu_macros.svh"

module mem (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic                        ex_valid_i,
    input  pipeline_types::aluop_e      ex_op_i,
    input  logic [`LSU_DATA_W-1:0]      ex_addr_i,
    input  logic [4:0]                  ex_rd_i,
    input  logic [`LSU_DATA_W-1:0]      ex_st_data_i,
    input  logic                        dc_ack_i,
    input  logic [`LSU_DATA_W-1:0]      dc_rdata_i,
    output logic                        pause_o,
    output logic                        dc_req_o,
    output logic [`LSU_DATA_W-1:0]      dc_addr_o,
    output logic                        dc_we_o,
    output logic [3:0]                  dc_wstrb_o,
    output logic [`LSU_DATA_W-1:0]      dc_wdata_o,
    output logic                        wb_valid_o,
    output logic                        wb_we_o,
    output logic [4:0]                  wb_rd_o,
    output logic [`LSU_DATA_W-1:0]      wb_data_o,
    output logic                        excp_o,
    output pipeline_types::excp_cause_e excp_cause_o
);
    import pipeline_types::*;

    // M_WAIT parks an access until the previous ack has dropped
    typedef enum logic [1:0] {M_IDLE, M_WAIT, M_REQ} mem_state_e;

    mem_state_e             state_q;
    aluop_e                 op_q;
    logic [4:0]             rd_q;
    logic                   resv_valid_q;
    logic [`LSU_DATA_W-3:0] resv_addr_q;

    logic                   accept;
    logic                   ack_seen;
    logic                   is_load;
    logic                   is_store;
    logic                   misaligned;
    logic                   resv_hit;
    logic                   need_access;
    logic [3:0]             st_strb;
    logic [`LSU_DATA_W-1:0] st_data;
    logic [7:0]             ld_byte;
    logic [15:0]            ld_half;
    logic [`LSU_DATA_W-1:0] ld_data;

    assign pause_o = (state_q != M_IDLE);
    assign accept = ex_valid_i && !pause_o;
    assign dc_req_o = (state_q == M_REQ);
    assign ack_seen = dc_req_o && dc_ack_i;

    always_comb begin
        is_load = 1'b0;
        is_store = 1'b0;
        misaligned = 1'b0;
        st_strb = 4'b0000;
        st_data = ex_st_data_i;
        case (ex_op_i)
            ALU_LDB, ALU_LDBU: is_load = 1'b1;
            ALU_LDH, ALU_LDHU: begin
                is_load = 1'b1;
                misaligned = ex_addr_i[0];
            end
            ALU_LDW, ALU_LLW: begin
                is_load = 1'b1;
                misaligned = |ex_addr_i[1:0];
            end
            ALU_STB: begin
                is_store = 1'b1;
                st_strb = 4'b0001 << ex_addr_i[1:0];
                st_data = {4{ex_st_data_i[7:0]}};
            end
            ALU_STH: begin
                is_store = 1'b1;
                misaligned = ex_addr_i[0];
                st_strb = ex_addr_i[1] ? 4'b1100 : 4'b0011;
                st_data = {2{ex_st_data_i[15:0]}};
            end
            ALU_STW, ALU_SCW: begin
                is_store = 1'b1;
                misaligned = |ex_addr_i[1:0];
                st_strb = 4'b1111;
            end
            default: ;
        endcase
    end

    assign resv_hit = resv_valid_q && (resv_addr_q == ex_addr_i[`LSU_DATA_W-1:2]);
    // a failed sc.w completes without touching the cache
    assign need_access = !misaligned &&
                         (is_load || (is_store && ((ex_op_i != ALU_SCW) || resv_hit)));

    // lane select on the returned word
    assign ld_byte = dc_rdata_i[{dc_addr_o[1:0], 3'b000} +: 8];
    assign ld_half = dc_addr_o[1] ? dc_rdata_i[31:16] : dc_rdata_i[15:0];

    always_comb begin
        case (op_q)
            ALU_LDB:  ld_data = {{24{ld_byte[7]}}, ld_byte};
            ALU_LDBU: ld_data = {24'b0, ld_byte};
            ALU_LDH:  ld_data = {{16{ld_half[15]}}, ld_half};
            ALU_LDHU: ld_data = {16'b0, ld_half};
            ALU_SCW:  ld_data = `LSU_DATA_W'(1);
            default:  ld_data = dc_rdata_i;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= M_IDLE;
            resv_valid_q <= 1'b0;
            wb_valid_o <= 1'b0;
            wb_we_o <= 1'b0;
            excp_o <= 1'b0;
            excp_cause_o <= EXC_NONE;
        end else begin
            wb_valid_o <= 1'b0;
            wb_we_o <= 1'b0;
            excp_o <= 1'b0;
            excp_cause_o <= EXC_NONE;
            case (state_q)
                M_IDLE: begin
                    if (accept && need_access) begin
                        state_q <= dc_ack_i ? M_WAIT : M_REQ;
                    end
                end
                M_WAIT: begin
                    if (!dc_ack_i) begin
                        state_q <= M_REQ;
                    end
                end
                M_REQ: begin
                    if (ack_seen) begin
                        state_q <= M_IDLE;
                        wb_valid_o <= 1'b1;
                        wb_we_o <= !(op_q inside {ALU_STB, ALU_STH, ALU_STW});
                    end
                end
                default: state_q <= M_IDLE;
            endcase
            if (accept && !need_access) begin
                wb_valid_o <= 1'b1;
                wb_we_o <= (ex_op_i == ALU_SCW) && !misaligned;
                excp_o <= misaligned;
                excp_cause_o <= !misaligned ? EXC_NONE : (is_store ? EXC_ALE_ST : EXC_ALE);
            end
            // ll/sc reservation
            if (accept) begin
                if ((ex_op_i == ALU_LLW) && !misaligned) begin
                    resv_valid_q <= 1'b1;
                    resv_addr_q <= ex_addr_i[`LSU_DATA_W-1:2];
                end else if ((ex_op_i == ALU_SCW) || (is_store && !misaligned && resv_hit)) begin
                    resv_valid_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q <= ex_op_i;
            rd_q <= ex_rd_i;
            dc_addr_o <= ex_addr_i;
            dc_we_o <= is_store;
            dc_wstrb_o <= st_strb;
            dc_wdata_o <= st_data;
        end
        if (ack_seen) begin
            wb_rd_o <= rd_q;
            wb_data_o <= ld_data;
        end else if (accept && !need_access) begin
            wb_rd_o <= ex_rd_i;
            wb_data_o <= '0;
        end
    end

    // a new request only starts once the previous ack is gone
    a_req_after_ack_low: assert property (@(posedge clk) disable iff (rst_i)
        $rose(dc_req_o) |-> !dc_ack_i);

    // the slave lets go of ack only after req has dropped
    a_ack_drops_after_req: assert property (@(posedge clk) disable iff (rst_i)
        $fell(dc_ack_i) |-> !dc_req_o);

endmodule

/* pipeline_types.sv */
package pipeline_types;

    // load/store opcodes seen by the memory stage
    typedef enum logic [3:0] {
        ALU_NOP  = 4'd0,
        ALU_LDB  = 4'd1,
        ALU_LDBU = 4'd2,
        ALU_LDH  = 4'd3,
        ALU_LDHU = 4'd4,
        ALU_LDW  = 4'd5,
        ALU_LLW  = 4'd6,
        ALU_STB  = 4'd7,
        ALU_STH  = 4'd8,
        ALU_STW  = 4'd9,
        ALU_SCW  = 4'd10
    } aluop_e;

    // ALE split by access direction
    typedef enum logic [1:0] {
        EXC_NONE   = 2'd0,
        EXC_ALE    = 2'd1,
        EXC_ALE_ST = 2'd2
    } excp_cause_e;

endpackage
